//--- design/isaPkg.sv
// Instruction set opcodes, basic types, instruction formats and the decode-to-execute record
`default_nettype none

package isaPkg;

  // Basic field types
  typedef logic [6:0]  opcode_t;
  typedef logic [4:0]  regIdx_t;
  typedef logic [31:0] word_t;

  // Opcode values of the supported subset
  localparam opcode_t OPCODE_ADD  = 7'h00;
  localparam opcode_t OPCODE_SUB  = 7'h01;
  localparam opcode_t OPCODE_MOV  = 7'h14;
  localparam opcode_t OPCODE_MOVI = 7'h15;
  localparam opcode_t OPCODE_BEQ  = 7'h30;
  localparam opcode_t OPCODE_JUMP = 7'h31;
  localparam opcode_t OPCODE_NOP  = 7'h7f;

  // Bubble word, its opcode field decodes as NOP
  localparam word_t NOP_WORD = 32'hffff_ffff;

  // Register format for ADD, SUB, MOV and BEQ
  // Offset is signed and counted in words
  typedef struct packed {
    opcode_t    opcode;
    regIdx_t    dst;
    regIdx_t    src1;
    regIdx_t    src2;
    logic [9:0] offset;
  } rFormat_t;

  // Immediate format for MOVI (value) and JUMP (word offset)
  typedef struct packed {
    opcode_t     opcode;
    regIdx_t     dst;
    logic [19:0] imm;
  } iFormat_t;

  // Same word seen through either format
  typedef union packed {
    rFormat_t r;
    iFormat_t i;
  } instWord_t;

  // Decoded instruction handed to execute
  // Offset already sign-extended to the 20-bit immediate width
  typedef struct packed {
    logic        valid;
    word_t       pc;
    opcode_t     opcode;
    regIdx_t     dst;
    word_t       srcA;
    word_t       srcB;
    logic [19:0] offset;
  } execOp_t;

endpackage

`default_nettype wire

//--- design/busPkg.sv
// Wishbone request and response structs, retire record, reset PC and trace queue depth
`default_nettype none

package busPkg;

  // Fetch starts here after reset
  localparam isaPkg::word_t RESET_PC = 32'h0000_1000;

  // Bytes per instruction
  localparam isaPkg::word_t PC_STEP = 32'd4;

  // Retire FIFO entries
  localparam int TRACE_DEPTH = 4;

  // Instruction bus, read only
  typedef struct packed {
    logic          cyc;
    logic          stb;
    isaPkg::word_t adr;
  } wbReadReq_t;

  typedef struct packed {
    logic          ack;
    isaPkg::word_t dat;
  } wbReadRsp_t;

  // One retired instruction
  typedef struct packed {
    isaPkg::word_t   pc;
    isaPkg::regIdx_t dst;
    logic            writesReg;
    isaPkg::word_t   value;
  } retireRec_t;

  // Trace bus, write only so no we line
  typedef struct packed {
    logic       cyc;
    logic       stb;
    retireRec_t dat;
  } traceReq_t;

  typedef struct packed {
    logic ack;
  } traceRsp_t;

endpackage

`default_nettype wire

//--- design/regFile.sv
// General register file, two asynchronous read ports and one synchronous write port
`timescale 1ns/1ns
`default_nettype none

module regFile import isaPkg::*; (
  input  logic    clk,
  input  regIdx_t rdIdxA,
  input  regIdx_t rdIdxB,
  output word_t   rdDataA,
  output word_t   rdDataB,
  input  logic    wrEn,
  input  regIdx_t wrIdx,
  input  word_t   wrData
);

  word_t regs [32];

  // Writes to r0 are dropped
  always_ff @(posedge clk)
  begin
    if (wrEn && wrIdx != '0)
      regs[wrIdx] <= wrData;
  end

  // r0 always reads zero
  assign rdDataA = (rdIdxA == '0) ? '0 : regs[rdIdxA];
  assign rdDataB = (rdIdxB == '0) ? '0 : regs[rdIdxB];

endmodule

`default_nettype wire

//--- design/instFetch.sv
// Fetch unit with PC register, Wishbone read master and a one-word hold buffer
`timescale 1ns/1ns
`default_nettype none

module instFetch import isaPkg::*, busPkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       hold,
  input  logic       redirect,
  input  word_t      target,
  output wbReadReq_t iBusReq,
  input  wbReadRsp_t iBusRsp,
  output word_t      fetchWord,
  output word_t      fetchPc,
  output logic       fetchValid
);

  word_t pc;
  word_t reqAdr;
  logic  busy;
  logic  discard;
  logic  bufValid;
  word_t bufWord;
  word_t bufPc;
  logic  ackNow;
  logic  accept;

  // Ack of the open cycle
  assign ackNow = busy && iBusRsp.ack;
  // Word on the live path, a redirect in the same cycle kills it
  assign accept = ackNow && !discard && !redirect;

  // cyc and stb move together, adr latched at cycle open
  assign iBusReq = '{cyc: busy, stb: busy, adr: reqAdr};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc       <= RESET_PC;
      busy     <= 1'b0;
      discard  <= 1'b0;
      bufValid <= 1'b0;
    end
    else
    begin
      // Drop after ack, reopen once nothing waits in the buffer
      if (ackNow)
        busy <= 1'b0;
      else if (!busy && !bufValid)
        busy <= 1'b1;

      // Wrong-path read still in flight
      if (ackNow)
        discard <= 1'b0;
      else if (busy && redirect)
        discard <= 1'b1;

      if (redirect)
        pc <= target;
      else if (accept)
        pc <= pc + PC_STEP;

      // Park the word while decode is stalled
      if (redirect)
        bufValid <= 1'b0;
      else if (accept && hold)
        bufValid <= 1'b1;
      else if (!hold)
        bufValid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    // New address, target wins in a redirect cycle
    if (!busy && !bufValid)
      reqAdr <= redirect ? target : pc;
    if (accept)
    begin
      bufWord <= iBusRsp.dat;
      bufPc   <= reqAdr;
    end
  end

  // Buffered word first, else straight from the bus
  assign fetchValid = bufValid || (ackNow && !discard);
  assign fetchWord  = bufValid ? bufWord : iBusRsp.dat;
  assign fetchPc    = bufValid ? bufPc : reqAdr;

endmodule

`default_nettype wire

//--- design/decodeStage.sv
// Decode stage with instruction register, operand read, execute bypass and op build
`timescale 1ns/1ns
`default_nettype none

module decodeStage import isaPkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  word_t   fetchWord,
  input  word_t   fetchPc,
  input  logic    fetchValid,
  input  logic    hold,
  input  logic    flush,
  input  logic    bypassEn,
  input  regIdx_t bypassIdx,
  input  word_t   bypassData,
  input  logic    wrEn,
  input  regIdx_t wrIdx,
  input  word_t   wrData,
  output execOp_t op
);

  instWord_t inst;
  word_t     instPc;
  word_t     rfA;
  word_t     rfB;
  logic      hitA;
  logic      hitB;

  // Decode register, NOP when nothing was fetched
  always_ff @(posedge clk)
  begin
    if (rst || flush)
      inst <= NOP_WORD;
    else if (!hold)
      inst <= fetchValid ? fetchWord : NOP_WORD;
  end

  always_ff @(posedge clk)
  begin
    if (!hold)
      instPc <= fetchPc;
  end

  // Source fields always come from the register format
  regFile regs (
    .clk     (clk),
    .rdIdxA  (inst.r.src1),
    .rdIdxB  (inst.r.src2),
    .rdDataA (rfA),
    .rdDataB (rfB),
    .wrEn    (wrEn),
    .wrIdx   (wrIdx),
    .wrData  (wrData)
  );

  // Execute result not yet in the file, r0 never bypassed
  assign hitA = bypassEn && bypassIdx == inst.r.src1 && inst.r.src1 != '0;
  assign hitB = bypassEn && bypassIdx == inst.r.src2 && inst.r.src2 != '0;

  always_comb
  begin
    op.valid  = inst.r.opcode != OPCODE_NOP;
    op.pc     = instPc;
    op.opcode = inst.r.opcode;
    op.dst    = inst.r.dst;
    op.srcA   = hitA ? bypassData : rfA;
    op.srcB   = hitB ? bypassData : rfB;
    // BEQ has the short offset, MOVI and JUMP the 20-bit one
    if (inst.r.opcode == OPCODE_BEQ)
      op.offset = {{10{inst.r.offset[9]}}, inst.r.offset};
    else
      op.offset = inst.i.imm;
  end

endmodule

`default_nettype wire

//--- design/execStage.sv
// Execute stage with ALU, branch resolution, register write and retire push
`timescale 1ns/1ns
`default_nettype none

module execStage import isaPkg::*, busPkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  execOp_t    op,
  input  logic       full,
  output logic       hold,
  output logic       redirect,
  output word_t      target,
  output logic       wrEn,
  output regIdx_t    wrIdx,
  output word_t      wrData,
  output logic       push,
  output retireRec_t rec
);

  execOp_t cur;
  word_t   immExt;
  word_t   result;
  logic    writesReg;
  logic    taken;

  // Execute register, squashed behind a taken branch
  always_ff @(posedge clk)
  begin
    if (rst || redirect)
    begin
      cur.valid  <= 1'b0;
      cur.opcode <= OPCODE_NOP;
    end
    else if (!hold)
      cur <= op;
  end

  assign immExt = {{12{cur.offset[19]}}, cur.offset};

  always_comb
  begin
    case (cur.opcode)
      OPCODE_ADD:  result = cur.srcA + cur.srcB;
      OPCODE_SUB:  result = cur.srcA - cur.srcB;
      OPCODE_MOV:  result = cur.srcA;
      OPCODE_MOVI: result = immExt;
      // Branches and the rest retire value zero
      default:     result = '0;
    endcase
  end

  assign writesReg = cur.valid && (cur.opcode == OPCODE_ADD || cur.opcode == OPCODE_SUB ||
                                   cur.opcode == OPCODE_MOV || cur.opcode == OPCODE_MOVI);
  assign taken = cur.valid && ((cur.opcode == OPCODE_BEQ && cur.srcA == cur.srcB) ||
                               cur.opcode == OPCODE_JUMP);

  // Whole front stalls while the retire FIFO is full
  assign hold     = full;
  assign redirect = taken && !full;
  // Offset in words
  assign target   = cur.pc + {immExt[29:0], 2'b00};

  // Write doubles as the bypass into decode
  assign wrEn   = writesReg && !full;
  assign wrIdx  = cur.dst;
  assign wrData = result;

  assign push = cur.valid && !full;
  assign rec  = '{pc: cur.pc,
                  dst: writesReg ? cur.dst : '0,
                  writesReg: writesReg,
                  value: result};

endmodule

`default_nettype wire

//--- design/retireQueue.sv
// Retire record FIFO drained by a Wishbone write master on the trace bus
`timescale 1ns/1ns
`default_nettype none

module retireQueue import busPkg::*; #(
  parameter int DEPTH = TRACE_DEPTH
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       push,
  input  retireRec_t rec,
  output logic       full,
  output traceReq_t  traceReq,
  input  traceRsp_t  traceRsp
);

  localparam int PTR_W = $clog2(DEPTH);

  retireRec_t       mem [DEPTH];
  logic [PTR_W:0]   wrPtr;
  logic [PTR_W:0]   rdPtr;
  logic             busy;
  logic             empty;
  logic             pop;

  // Extra pointer bit tells full from empty
  assign empty = wrPtr == rdPtr;
  assign full  = wrPtr[PTR_W] != rdPtr[PTR_W] && wrPtr[PTR_W-1:0] == rdPtr[PTR_W-1:0];
  assign pop   = busy && traceRsp.ack;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      busy  <= 1'b0;
    end
    else
    begin
      if (push && !full)
        wrPtr <= wrPtr + 1'b1;
      if (pop)
        rdPtr <= rdPtr + 1'b1;
      // One idle cycle after every ack
      if (pop)
        busy <= 1'b0;
      else if (!busy && !empty)
        busy <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push && !full)
      mem[wrPtr[PTR_W-1:0]] <= rec;
  end

  // Head only moves on ack, so data holds while stb waits
  assign traceReq = '{cyc: busy, stb: busy, dat: mem[rdPtr[PTR_W-1:0]]};

endmodule

`default_nettype wire

//--- design/cpuCore.sv
// Core top level wiring fetch, decode, execute and the retire queue
`timescale 1ns/1ns
`default_nettype none

module cpuCore import isaPkg::*, busPkg::*; (
  input  logic       clk,
  input  logic       rst,
  output wbReadReq_t iBusReq,
  input  wbReadRsp_t iBusRsp,
  output traceReq_t  traceReq,
  input  traceRsp_t  traceRsp
);

  word_t      fetchWord;
  word_t      fetchPc;
  logic       fetchValid;
  logic       hold;
  logic       redirect;
  word_t      target;
  execOp_t    op;
  logic       wrEn;
  regIdx_t    wrIdx;
  word_t      wrData;
  logic       push;
  retireRec_t rec;
  logic       full;

  instFetch fetch (
    .clk, .rst, .hold, .redirect, .target,
    .iBusReq, .iBusRsp,
    .fetchWord, .fetchPc, .fetchValid
  );

  // Register write also feeds the bypass
  decodeStage decode (
    .clk, .rst, .fetchWord, .fetchPc, .fetchValid, .hold,
    .flush      (redirect),
    .bypassEn   (wrEn),
    .bypassIdx  (wrIdx),
    .bypassData (wrData),
    .wrEn, .wrIdx, .wrData, .op
  );

  execStage exec (
    .clk, .rst, .op, .full, .hold, .redirect, .target,
    .wrEn, .wrIdx, .wrData, .push, .rec
  );

  retireQueue #(.DEPTH(TRACE_DEPTH)) retire (
    .clk, .rst, .push, .rec, .full, .traceReq, .traceRsp
  );

endmodule

`default_nettype wire

//--- testbench/cpuCore_props.sv
// Wishbone handshake assertions for the instruction and trace buses of cpuCore
`timescale 1ns/1ns
`default_nettype none

module cpuCore_props import busPkg::*; (
  input logic       clk,
  input logic       rst,
  input wbReadReq_t iBusReq,
  input wbReadRsp_t iBusRsp,
  input traceReq_t  traceReq,
  input traceRsp_t  traceRsp
);

  // stb only inside an open cycle
  iStbInCyc: assert property (@(posedge clk) disable iff (rst) iBusReq.stb |-> iBusReq.cyc)
    else $error("iBus stb raised without cyc");
  tStbInCyc: assert property (@(posedge clk) disable iff (rst) traceReq.stb |-> traceReq.cyc)
    else $error("trace stb raised without cyc");

  // Request held steady until ack
  iAdrStable: assert property (@(posedge clk) disable iff (rst)
    iBusReq.stb && !iBusRsp.ack |=> $stable(iBusReq.adr))
    else $error("iBus adr changed while stb waited");
  tRecStable: assert property (@(posedge clk) disable iff (rst)
    traceReq.stb && !traceRsp.ack |=> $stable(traceReq.dat))
    else $error("trace record changed while stb waited");

  // One idle cycle after each ack
  iCycDrop: assert property (@(posedge clk) disable iff (rst)
    iBusReq.cyc && iBusRsp.ack |=> !iBusReq.cyc)
    else $error("iBus cyc still high after ack");
  tCycDrop: assert property (@(posedge clk) disable iff (rst)
    traceReq.cyc && traceRsp.ack |=> !traceReq.cyc)
    else $error("trace cyc still high after ack");

endmodule

`default_nettype wire

//--- testbench/cpuCoreTb.sv
// Testbench for cpuCore with program table, bus responders, ISA model, checks and timeout
`timescale 1ns/1ns
`default_nettype none

module cpuCoreTb import isaPkg::*, busPkg::*; ();

  localparam int ROWS       = 20;
  localparam int NUM_TESTS  = 4;
  localparam int TEST_LIMIT = ROWS * 12;
  localparam int QUIET      = 16;

  // One program row, word plus expected retirement
  typedef struct packed {
    word_t inst;
    logic  retires;
  } progRow_t;

  // Wait state setup of one run
  typedef struct packed {
    logic       fetchRandom;
    logic [2:0] traceBase;
    logic       traceRandom;
    logic       expectFull;
  } testCfg_t;

  logic       clk;
  logic       rst;
  wbReadReq_t iBusReq;
  wbReadRsp_t iBusRsp;
  traceReq_t  traceReq;
  traceRsp_t  traceRsp;

  progRow_t   prog [ROWS];
  testCfg_t   tests [NUM_TESTS];
  string      testNames [NUM_TESTS];
  testCfg_t   cfg;
  retireRec_t recs [$];
  retireRec_t expRecs [$];
  word_t      modelRegs [32];
  logic [31:0] rng;
  logic [1:0] iWait;
  logic [2:0] tWait;
  logic       sawFull;
  logic       reported;
  int         cycles = 0;
  int         startCycle;
  int         errors;
  int         failedTests;

  cpuCore UUT (
    .clk      (clk),
    .rst      (rst),
    .iBusReq  (iBusReq),
    .iBusRsp  (iBusRsp),
    .traceReq (traceReq),
    .traceRsp (traceRsp)
  );

  bind cpuCore cpuCore_props props (
    .clk      (clk),
    .rst      (rst),
    .iBusReq  (iBusReq),
    .iBusRsp  (iBusRsp),
    .traceReq (traceReq),
    .traceRsp (traceRsp)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic word_t encR(input opcode_t opc, input regIdx_t d, input regIdx_t s1,
                                 input regIdx_t s2, input logic [9:0] off);
    rFormat_t r;
    r = '{opcode: opc, dst: d, src1: s1, src2: s2, offset: off};
    return r;
  endfunction

  function automatic word_t encI(input opcode_t opc, input regIdx_t d, input logic [19:0] imm);
    iFormat_t i;
    i = '{opcode: opc, dst: d, imm: imm};
    return i;
  endfunction

  // Program rows from RESET_PC, NOP everywhere else
  function automatic word_t fetchData(input word_t adr);
    word_t idx;
    idx = (adr - RESET_PC) >> 2;
    if (adr >= RESET_PC && adr[1:0] == 2'b00 && idx < ROWS)
      return prog[idx].inst;
    return NOP_WORD;
  endfunction

  task automatic checkRec(input retireRec_t got, input retireRec_t exp, input string what);
    if (got !== exp)
    begin
      errors++;
      $display("ERR %0t: %s pc %h dst %0d wr %b value %h, expected pc %h dst %0d wr %b value %h",
               $time, what, got.pc, got.dst, got.writesReg, got.value,
               exp.pc, exp.dst, exp.writesReg, exp.value);
    end
  endtask

  task automatic checkWord(input word_t got, input word_t exp, input string what);
    if (got !== exp)
    begin
      errors++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Dependent chains, taken and untaken BEQ, JUMP, skipped rows
  task automatic loadProgram();
    prog[0]  = '{encI(OPCODE_MOVI, 5'd1, 20'd5), 1'b1};
    prog[1]  = '{encI(OPCODE_MOVI, 5'd2, 20'hffffd), 1'b1};
    prog[2]  = '{encR(OPCODE_ADD, 5'd3, 5'd1, 5'd2, 10'd0), 1'b1};
    prog[3]  = '{encR(OPCODE_SUB, 5'd4, 5'd3, 5'd1, 10'd0), 1'b1};
    prog[4]  = '{encR(OPCODE_MOV, 5'd5, 5'd4, 5'd0, 10'd0), 1'b1};
    prog[5]  = '{encR(OPCODE_BEQ, 5'd0, 5'd5, 5'd2, 10'd3), 1'b1};
    prog[6]  = '{encI(OPCODE_MOVI, 5'd6, 20'd99), 1'b0};
    prog[7]  = '{encI(OPCODE_MOVI, 5'd7, 20'd77), 1'b0};
    prog[8]  = '{encR(OPCODE_ADD, 5'd6, 5'd5, 5'd5, 10'd0), 1'b1};
    prog[9]  = '{encR(OPCODE_BEQ, 5'd0, 5'd1, 5'd2, 10'd2), 1'b1};
    prog[10] = '{encI(OPCODE_JUMP, 5'd0, 20'd3), 1'b1};
    prog[11] = '{encI(OPCODE_MOVI, 5'd8, 20'd1), 1'b0};
    prog[12] = '{encR(OPCODE_ADD, 5'd1, 5'd1, 5'd1, 10'd0), 1'b0};
    prog[13] = '{encR(OPCODE_SUB, 5'd7, 5'd6, 5'd4, 10'd0), 1'b1};
    prog[14] = '{encR(OPCODE_ADD, 5'd8, 5'd7, 5'd7, 10'd0), 1'b1};
    prog[15] = '{encR(OPCODE_MOV, 5'd9, 5'd8, 5'd0, 10'd0), 1'b1};
    prog[16] = '{NOP_WORD, 1'b0};
    prog[17] = '{encI(OPCODE_MOVI, 5'd10, 20'h7ffff), 1'b1};
    prog[18] = '{encR(OPCODE_ADD, 5'd11, 5'd10, 5'd1, 10'd0), 1'b1};
    prog[19] = '{encR(OPCODE_SUB, 5'd12, 5'd11, 5'd10, 10'd0), 1'b1};
  endtask

  // Columns: fetchRandom, traceBase, traceRandom, expectFull
  task automatic loadTests();
    tests[0] = '{1'b0, 3'd0, 1'b0, 1'b0};
    tests[1] = '{1'b1, 3'd0, 1'b0, 1'b0};
    tests[2] = '{1'b0, 3'd4, 1'b0, 1'b1};
    tests[3] = '{1'b1, 3'd2, 1'b1, 1'b0};
    testNames[0] = "no wait states";
    testNames[1] = "random fetch waits";
    testNames[2] = "slow trace sink";
    testNames[3] = "random waits on both buses";
  endtask

  // ISA walk over row indices, gives the expected trace
  task automatic buildExpected();
    instWord_t  w;
    retireRec_t r;
    logic       ran [ROWS];
    logic       retire;
    int         idx;
    int         next;
    int         steps;
    expRecs.delete();
    foreach (modelRegs[k])
      modelRegs[k] = '0;
    foreach (ran[k])
      ran[k] = 1'b0;
    idx = 0;
    steps = 0;
    while (idx >= 0 && idx < ROWS && steps < 4 * ROWS)
    begin
      w = prog[idx].inst;
      next = idx + 1;
      steps++;
      retire = 1'b1;
      r = '{pc: RESET_PC + idx * 4, dst: w.r.dst, writesReg: 1'b1, value: '0};
      case (w.r.opcode)
        OPCODE_ADD:  r.value = modelRegs[w.r.src1] + modelRegs[w.r.src2];
        OPCODE_SUB:  r.value = modelRegs[w.r.src1] - modelRegs[w.r.src2];
        OPCODE_MOV:  r.value = modelRegs[w.r.src1];
        OPCODE_MOVI: r.value = {{12{w.i.imm[19]}}, w.i.imm};
        OPCODE_BEQ:
        begin
          r.dst = '0;
          r.writesReg = 1'b0;
          if (modelRegs[w.r.src1] == modelRegs[w.r.src2])
            next = idx + $signed(w.r.offset);
        end
        OPCODE_JUMP:
        begin
          r.dst = '0;
          r.writesReg = 1'b0;
          next = idx + $signed(w.i.imm);
        end
        default: retire = 1'b0;
      endcase
      if (retire)
        expRecs.push_back(r);
      if (retire && r.writesReg && r.dst != '0)
        modelRegs[r.dst] = r.value;
      ran[idx] = retire;
      idx = next;
    end
    foreach (ran[k])
      if (ran[k] !== prog[k].retires)
      begin
        errors++;
        $display("Program table row %0d retire flag disagrees with the ISA model", k);
      end
  endtask

  // Three reset cycles, trace bus must stay idle
  task automatic resetCore();
    @(posedge clk);
    rst <= 1'b1;
    startCycle = cycles;
    for (int i = 0; i < 3; i++)
    begin
      @(posedge clk);
      if (i > 0 && traceReq.cyc)
      begin
        errors++;
        $display("Trace bus cycle open during reset at %0t", $time);
      end
    end
    rst <= 1'b0;
    recs.delete();
    sawFull = 1'b0;
  endtask

  task automatic runTest(input int t);
    word_t traced [32];
    int    errsBefore;
    int    n;
    cfg = tests[t];
    errsBefore = errors;
    resetCore();
    while (!iBusReq.cyc)
      @(posedge clk);
    checkWord(iBusReq.adr, RESET_PC, "first fetch address");
    while (recs.size() < expRecs.size())
      @(posedge clk);
    // Quiet period catches extra records
    repeat (QUIET) @(posedge clk);
    if (recs.size() != expRecs.size())
    begin
      errors++;
      $display("Test %0d trace carried %0d records where %0d were expected",
               t, recs.size(), expRecs.size());
    end
    n = (recs.size() < expRecs.size()) ? recs.size() : expRecs.size();
    for (int i = 0; i < n; i++)
      checkRec(recs[i], expRecs[i], $sformatf("record %0d", i));
    // Register state rebuilt from trace values
    foreach (traced[k])
      traced[k] = '0;
    foreach (recs[i])
      if (recs[i].writesReg && recs[i].dst != '0)
        traced[recs[i].dst] = recs[i].value;
    for (int k = 1; k < 32; k++)
      checkWord(traced[k], modelRegs[k], $sformatf("r%0d", k));
    if (cfg.expectFull && !sawFull)
    begin
      errors++;
      $display("Test %0d never filled the trace queue", t);
    end
    if (errors != errsBefore)
      failedTests++;
    $display("Test %0d %s: %0d records, %s", t, testNames[t], recs.size(),
             (errors == errsBefore) ? "ok" : "mismatch");
  endtask

  // Memory and trace sink, waits drawn on each ack
  always @(posedge clk)
  begin
    if (rst)
    begin
      iBusRsp.ack <= 1'b0;
      traceRsp.ack <= 1'b0;
      iWait <= '0;
      tWait <= cfg.traceBase;
    end
    else
    begin
      if (iBusRsp.ack)
        iBusRsp.ack <= 1'b0;
      else if (iBusReq.cyc && iBusReq.stb)
      begin
        if (iWait == '0)
        begin
          iBusRsp <= '{ack: 1'b1, dat: fetchData(iBusReq.adr)};
          rng = xorshift(rng);
          iWait <= cfg.fetchRandom ? rng[1:0] : 2'd0;
        end
        else
          iWait <= iWait - 2'd1;
      end
      if (traceRsp.ack)
        traceRsp.ack <= 1'b0;
      else if (traceReq.cyc && traceReq.stb)
      begin
        if (tWait == '0)
        begin
          traceRsp.ack <= 1'b1;
          recs.push_back(traceReq.dat);
          rng = xorshift(rng);
          tWait <= cfg.traceBase + (cfg.traceRandom ? {1'b0, rng[1:0]} : 3'd0);
        end
        else
          tWait <= tWait - 3'd1;
      end
      if (UUT.full)
        sawFull = 1'b1;
    end
  end

  // Per-test cycle budget
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles - startCycle > TEST_LIMIT)
    begin
      reported = 1'b1;
      $display("Timeout, a test ran past %0d cycles without finishing", TEST_LIMIT);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    iBusRsp = '0;
    traceRsp = '0;
    cfg = '0;
    rng = 32'hb875_8314;
    iWait = '0;
    tWait = '0;
    sawFull = 1'b0;
    reported = 1'b0;
    startCycle = 0;
    errors = 0;
    failedTests = 0;
    loadProgram();
    loadTests();
    buildExpected();
    for (int t = 0; t < NUM_TESTS; t++)
      runTest(t);
    $display("Tests run %0d, failed %0d, check errors %0d", NUM_TESTS, failedTests, errors);
    reported = 1'b1;
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  // Run stopped early, e.g. by an assertion
  final
  begin
    if (!reported)
      $display("Result: FAILED");
  end

endmodule

`default_nettype wire

//--- cpuCore.f
design/isaPkg.sv
design/busPkg.sv
design/regFile.sv
design/instFetch.sv
design/decodeStage.sv
design/execStage.sv
design/retireQueue.sv
design/cpuCore.sv
testbench/cpuCore_props.sv
testbench/cpuCoreTb.sv

//--- run.sh
#!/bin/sh
# Build and run the cpuCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cpuCoreTb \
  -f cpuCore.f --Mdir obj_dir -o cpuCoreSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/cpuCoreSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
  exit 0
fi
echo "Pass line missing from sim.log"
exit 1
